// ==== files.f ====
logic/dmr_pkg.sv
logic/dmr_cfg_regs.sv
logic/dmr_compare.sv
logic/dmr_checkpoint.sv
logic/dmr_ctrl.sv
logic/dmr_recovery.sv
logic/dmr_lockstep_top.sv
testbench/tb_dmr_lockstep.sv

// ==== logic/dmr_cfg_regs.sv ====
/*
 * Software register file: enable, recovery config, saturating
 * mismatch counter and mode status with combinational read back
 */
`timescale 1ns/1ps

module dmr_cfg_regs import dmr_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  reg_req_t            reg_req_i,
  output logic [RegDataW-1:0] reg_rdata_o,
  input  dmr_mode_e           mode_i,
  input  logic                force_clr_i,
  input  logic                incr_mismatch_i,
  output dmr_cfg_t            cfg_o
);

  logic                    enable_q;
  logic                    rapid_q;
  logic                    force_q;
  logic [MismatchCntW-1:0] mismatch_cnt_q;

  // Write decode
  logic wr_enable, wr_config, wr_mismatch;

  assign wr_enable   = reg_req_i.we && (reg_req_i.addr == REG_ENABLE);
  assign wr_config   = reg_req_i.we && (reg_req_i.addr == REG_CONFIG);
  assign wr_mismatch = reg_req_i.we && (reg_req_i.addr == REG_MISMATCH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q       <= 1'b0;
      rapid_q        <= 1'b0;
      force_q        <= 1'b0;
      mismatch_cnt_q <= '0;
    end else begin
      if (wr_enable) begin
        enable_q <= reg_req_i.wdata[0];
      end
      // Force bit is set by software, cleared by the FSM
      if (force_clr_i) begin
        force_q <= 1'b0;
      end
      if (wr_config) begin
        rapid_q <= reg_req_i.wdata[0];
        if (reg_req_i.wdata[1]) begin
          force_q <= 1'b1;
        end
      end
      // Any write clears the counter, otherwise count and saturate
      if (wr_mismatch) begin
        mismatch_cnt_q <= '0;
      end else if (incr_mismatch_i && (mismatch_cnt_q != '1)) begin
        mismatch_cnt_q <= mismatch_cnt_q + 1'b1;
      end
    end
  end

  assign cfg_o.enable         = enable_q;
  assign cfg_o.rapid_recovery = rapid_q;
  assign cfg_o.force_recovery = force_q;

  // Read mux, unused upper bits return zero
  always_comb begin
    reg_rdata_o = '0;
    case (reg_req_i.addr)
      REG_ENABLE:   reg_rdata_o[0] = enable_q;
      REG_CONFIG:   reg_rdata_o[1:0] = {force_q, rapid_q};
      REG_MISMATCH: reg_rdata_o = {{(RegDataW-MismatchCntW){1'b0}}, mismatch_cnt_q};
      REG_STATUS:   reg_rdata_o = {{(RegDataW-2){1'b0}}, mode_i};
      default:      reg_rdata_o = '0;
    endcase
  end

endmodule

// ==== logic/dmr_checkpoint.sv ====
/*
 * Checkpoint buffer holding the last agreed core state word
 */
`timescale 1ns/1ps

module dmr_checkpoint import dmr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  core_state_t agreed_i,
  output core_state_t ckpt_o
);

  logic              ckpt_valid_q;
  logic [StateW-1:0] ckpt_data_q;

  // Valid once anything has been agreed on
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ckpt_valid_q <= 1'b0;
    end else if (agreed_i.valid) begin
      ckpt_valid_q <= 1'b1;
    end
  end

  // Overwrite with every new agreed word
  always_ff @(posedge clk_i) begin
    if (agreed_i.valid) begin
      ckpt_data_q <= agreed_i.data;
    end
  end

  // Without a checkpoint the valid bit stays low
  assign ckpt_o.valid = ckpt_valid_q;
  assign ckpt_o.data  = ckpt_data_q;

endmodule

// ==== logic/dmr_compare.sv ====
/*
 * Registered lockstep comparator: mismatch pulse and agreed state word
 */
`timescale 1ns/1ps

module dmr_compare import dmr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  core_state_t core_a_i,
  input  core_state_t core_b_i,
  input  logic        lockstep_i,
  output logic        mismatch_o,
  output core_state_t agreed_o
);

  logic              both_valid;
  logic              equal;
  logic              mismatch_q;
  logic              agreed_valid_q;
  logic [StateW-1:0] agreed_data_q;

  // Only compare while the pair runs in lockstep
  assign both_valid = lockstep_i && core_a_i.valid && core_b_i.valid;
  assign equal      = (core_a_i.data == core_b_i.data);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_q     <= 1'b0;
      agreed_valid_q <= 1'b0;
    end else begin
      mismatch_q     <= both_valid && !equal;
      agreed_valid_q <= both_valid && equal;
    end
  end

  // Payload follows core A, only meaningful with the strobe
  always_ff @(posedge clk_i) begin
    if (both_valid && equal) begin
      agreed_data_q <= core_a_i.data;
    end
  end

  assign mismatch_o     = mismatch_q;
  assign agreed_o.valid = agreed_valid_q;
  assign agreed_o.data  = agreed_data_q;

endmodule

// ==== logic/dmr_ctrl.sv ====
/*
 * Lockstep control FSM: mode switching, recovery request,
 * setback and mismatch counting
 */
`timescale 1ns/1ps

module dmr_ctrl import dmr_pkg::*; #(
  parameter bit RapidRecovery = 1'b1
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  dmr_cfg_t  cfg_i,
  input  logic      fetch_en_i,
  input  logic      cores_synch_i,
  input  logic      mismatch_i,
  input  logic      recovery_done_i,
  output dmr_mode_e mode_o,
  output logic      lockstep_o,
  output logic      setback_o,
  output logic      grp_in_independent_o,
  output logic      recovery_req_o,
  output logic      force_clr_o,
  output logic      incr_mismatch_o
);

  dmr_mode_e mode_d, mode_q;
  logic      setback_d, setback_q;
  logic      rapid_en;
  logic      force_en;

  // Restore paths exist only when built with rapid recovery
  assign rapid_en = RapidRecovery && cfg_i.rapid_recovery;
  assign force_en = RapidRecovery && cfg_i.force_recovery;

  always_comb begin
    mode_d          = mode_q;
    recovery_req_o  = 1'b0;
    force_clr_o     = 1'b0;
    incr_mismatch_o = 1'b0;

    case (mode_q)
      NON_DMR: begin
        // Enter lockstep before startup or once cores are aligned
        if (cfg_i.enable && (!fetch_en_i || cores_synch_i)) begin
          mode_d = DMR_RUN;
        end
      end

      DMR_RUN: begin
        if (!cfg_i.enable) begin
          // Split back to independent mode
          mode_d = NON_DMR;
        end else begin
          // Count every mismatch, restore only if configured
          if (mismatch_i) begin
            incr_mismatch_o = 1'b1;
            if (rapid_en) begin
              mode_d         = DMR_RESTORE;
              recovery_req_o = 1'b1;
            end
          end
          // Software forced restore, not counted
          if (force_en) begin
            force_clr_o    = 1'b1;
            mode_d         = DMR_RESTORE;
            recovery_req_o = 1'b1;
          end
        end
      end

      DMR_RESTORE: begin
        if (recovery_done_i) begin
          mode_d = DMR_RUN;
        end
      end

      default: mode_d = NON_DMR;
    endcase

    // Before startup a cleared enable always drops to independent
    if (!fetch_en_i && !cfg_i.enable) begin
      mode_d = NON_DMR;
    end
  end

  // Cores held for every restore cycle
  assign setback_d = (mode_d == DMR_RESTORE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= NON_DMR;
      setback_q <= 1'b0;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

  assign mode_o               = mode_q;
  assign lockstep_o           = (mode_q == DMR_RUN);
  assign grp_in_independent_o = (mode_q == NON_DMR);
  assign setback_o            = setback_q;

endmodule

// ==== logic/dmr_lockstep_top.sv ====
/*
 * DMR lockstep top: register file, comparator, checkpoint,
 * control FSM and recovery unit
 */
`timescale 1ns/1ps

module dmr_lockstep_top import dmr_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  reg_req_t            reg_req_i,
  output logic [RegDataW-1:0] reg_rdata_o,
  input  core_state_t         core_a_i,
  input  core_state_t         core_b_i,
  input  logic                fetch_en_i,
  input  logic                cores_synch_i,
  output logic                setback_o,
  output logic                grp_in_independent_o,
  output core_state_t         restore_o
);

  // Config and status between register file and FSM
  dmr_cfg_t  cfg;
  dmr_mode_e mode;
  logic      force_clr;
  logic      incr_mismatch;

  // Comparator, checkpoint and recovery links
  logic        lockstep;
  logic        mismatch;
  core_state_t agreed;
  core_state_t ckpt;
  logic        recovery_req;
  logic        recovery_done;

  dmr_cfg_regs u_cfg_regs (
    .clk_i,
    .rst_ni,
    .reg_req_i,
    .reg_rdata_o,
    .mode_i          (mode),
    .force_clr_i     (force_clr),
    .incr_mismatch_i (incr_mismatch),
    .cfg_o           (cfg)
  );

  // Producer of agreed state words
  dmr_compare u_compare (
    .clk_i,
    .rst_ni,
    .core_a_i,
    .core_b_i,
    .lockstep_i (lockstep),
    .mismatch_o (mismatch),
    .agreed_o   (agreed)
  );

  dmr_checkpoint u_checkpoint (
    .clk_i,
    .rst_ni,
    .agreed_i (agreed),
    .ckpt_o   (ckpt)
  );

  dmr_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .cfg_i                (cfg),
    .fetch_en_i,
    .cores_synch_i,
    .mismatch_i           (mismatch),
    .recovery_done_i      (recovery_done),
    .mode_o               (mode),
    .lockstep_o           (lockstep),
    .setback_o,
    .grp_in_independent_o,
    .recovery_req_o       (recovery_req),
    .force_clr_o          (force_clr),
    .incr_mismatch_o      (incr_mismatch)
  );

  // Consumer of the checkpoint
  dmr_recovery u_recovery (
    .clk_i,
    .rst_ni,
    .recovery_req_i  (recovery_req),
    .ckpt_i          (ckpt),
    .restore_o,
    .recovery_done_o (recovery_done)
  );

endmodule

// ==== logic/dmr_pkg.sv ====
/*
 * Shared types for the DMR lockstep control: widths, mode and register
 * address enums, core state word, register request and config structs
 */
package dmr_pkg;

  // Core state word width
  localparam int unsigned StateW = 32;
  // Replay beats per restore
  localparam int unsigned RestoreBeats = 4;
  // Beat counter width in the recovery unit
  localparam int unsigned BeatCntW = $clog2(RestoreBeats);
  // Saturating mismatch counter width
  localparam int unsigned MismatchCntW = 16;
  // Register bus widths
  localparam int unsigned RegAddrW = 2;
  localparam int unsigned RegDataW = 32;

  // Redundancy mode of the core pair
  typedef enum logic [1:0] {
    NON_DMR     = 2'd0,
    DMR_RUN     = 2'd1,
    DMR_RESTORE = 2'd2
  } dmr_mode_e;

  // Software register map
  typedef enum logic [RegAddrW-1:0] {
    REG_ENABLE   = 2'd0,
    REG_CONFIG   = 2'd1,
    REG_MISMATCH = 2'd2,
    REG_STATUS   = 2'd3
  } dmr_reg_addr_e;

  // One core state word with its valid bit
  typedef struct packed {
    logic              valid;
    logic [StateW-1:0] data;
  } core_state_t;

  // Register write request, read address shared
  typedef struct packed {
    logic                we;
    dmr_reg_addr_e       addr;
    logic [RegDataW-1:0] wdata;
  } reg_req_t;

  // Config fields seen by the control FSM
  typedef struct packed {
    logic enable;
    logic rapid_recovery;
    logic force_recovery;
  } dmr_cfg_t;

endpackage

// ==== logic/dmr_recovery.sv ====
/*
 * Recovery unit replaying the checkpoint word for a fixed number of beats
 */
`timescale 1ns/1ps

module dmr_recovery import dmr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        recovery_req_i,
  input  core_state_t ckpt_i,
  output core_state_t restore_o,
  output logic        recovery_done_o
);

  logic                active_q;
  logic [BeatCntW-1:0] beat_q;
  logic                last_beat;

  assign last_beat = (beat_q == BeatCntW'(RestoreBeats - 1));

  // Beat counter, requests during a replay are ignored
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      beat_q   <= '0;
    end else if (active_q) begin
      if (last_beat) begin
        active_q <= 1'b0;
        beat_q   <= '0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end else if (recovery_req_i) begin
      active_q <= 1'b1;
      beat_q   <= '0;
    end
  end

  // Beats carry valid only with a checkpoint present
  assign restore_o.valid = active_q && ckpt_i.valid;
  assign restore_o.data  = ckpt_i.data;

  // Done with the final beat
  assign recovery_done_o = active_q && last_beat;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DMR lockstep testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f files.f --top-module tb_dmr_lockstep -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_tb > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "^TESTS PASSED$" "$LOG"; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail"
  exit 1
fi

// ==== testbench/dmr_vectors.txt ====
# op addr data count expected, all hex
# RD and IND/SETB compare with expected, REST expects that many beats
IND 0 0 0 1
SETB 0 0 0 0
RD 3 0 0 0
WR 0 1 0 0
RD 3 0 0 1
IND 0 0 0 0
FETCH 0 1 0 0
NE 0 0 3 0
NOREST 0 0 8 0
RD 2 0 0 3
WR 2 0 0 0
RD 2 0 0 0
WR 1 1 0 0
EQ 0 0 1 0
NE 0 0 1 0
REST 0 0 0 4
WAIT 0 0 2 0
RD 3 0 0 1
RD 2 0 0 1
WR 1 3 0 0
REST 0 0 0 4
WAIT 0 0 2 0
RD 2 0 0 1
RD 1 0 0 1
WR 0 0 0 0
WAIT 0 0 1 0
RD 3 0 0 0
IND 0 0 0 1
NE 0 0 3 0
WAIT 0 0 2 0
RD 2 0 0 1
WR 0 1 0 0
WAIT 0 0 2 0
RD 3 0 0 0
SYNCH 0 1 0 0
WAIT 0 0 2 0
RD 3 0 0 1

// ==== testbench/tb_dmr_lockstep.sv ====
/*
 * Testbench for the DMR lockstep top: vector file reader, register and
 * core stimulus, restore and level checks, watchdog
 */
`timescale 1ns/1ps

module tb_dmr_lockstep import dmr_pkg::*; ();

  localparam int unsigned WatchCyclesPerVec = 40;
  localparam int unsigned RestoreWaitMax    = 16;

  logic                clk_i;
  logic                rst_ni;
  reg_req_t            reg_req;
  logic [RegDataW-1:0] reg_rdata;
  core_state_t         core_a;
  core_state_t         core_b;
  logic                fetch_en;
  logic                cores_synch;
  logic                setback;
  logic                grp_in_independent;
  core_state_t         restore;

  // Vector table with one entry per operation
  string             vec_op[$];
  logic [31:0]       vec_addr[$];
  logic [31:0]       vec_data[$];
  logic [31:0]       vec_cnt[$];
  logic [31:0]       vec_exp[$];
  int unsigned       vec_count;
  bit                file_ok;
  // Reference model of the last word both cores agreed on
  logic [StateW-1:0] last_word;
  int unsigned       pass_cnt;
  int unsigned       fail_cnt;
  bit                test_ok;
  string             test_name;

  dmr_lockstep_top u_dut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .reg_req_i            (reg_req),
    .reg_rdata_o          (reg_rdata),
    .core_a_i             (core_a),
    .core_b_i             (core_b),
    .fetch_en_i           (fetch_en),
    .cores_synch_i        (cores_synch),
    .setback_o            (setback),
    .grp_in_independent_o (grp_in_independent),
    .restore_o            (restore)
  );

  // 20 ns clock
  always #10 clk_i = ~clk_i;

  // Fill the vector table
  // Lines whose first token is a lone # are comments
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [31:0] a, d, c, e;
    fd = $fopen("testbench/dmr_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file testbench/dmr_vectors.txt");
      file_ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0) begin
          n = $sscanf(line, "%s %h %h %h %h", op, a, d, c, e);
          if (n == 5 && op != "#") begin
            vec_op.push_back(op);
            vec_addr.push_back(a);
            vec_data.push_back(d);
            vec_cnt.push_back(c);
            vec_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
      file_ok = 1'b1;
    end
  endtask

  task automatic write_reg(input logic [31:0] a, input logic [31:0] d);
    @(posedge clk_i);
    reg_req.we    <= 1'b1;
    reg_req.addr  <= dmr_reg_addr_e'(a[RegAddrW-1:0]);
    reg_req.wdata <= d;
    @(posedge clk_i);
    reg_req.we    <= 1'b0;
  endtask

  // Read data is combinational and sampled mid cycle
  task automatic read_check(input logic [31:0] a, input logic [31:0] e);
    @(posedge clk_i);
    reg_req.we   <= 1'b0;
    reg_req.addr <= dmr_reg_addr_e'(a[RegAddrW-1:0]);
    @(negedge clk_i);
    if (reg_rdata !== e) begin
      $display("Error: %0s expected %h actual %h", test_name, e, reg_rdata);
      test_ok = 1'b0;
    end
  endtask

  // Both cores valid for n cycles
  // Core B gets bit 0 flipped on an unequal step
  task automatic step_cores(input int unsigned n, input bit unequal);
    logic [StateW-1:0] w;
    for (int unsigned i = 0; i < n; i++) begin
      w = $urandom;
      @(posedge clk_i);
      core_a.valid <= 1'b1;
      core_a.data  <= w;
      core_b.valid <= 1'b1;
      core_b.data  <= unequal ? {w[StateW-1:1], ~w[0]} : w;
      if (!unequal) begin
        last_word = w;
      end
    end
    @(posedge clk_i);
    core_a.valid <= 1'b0;
    core_b.valid <= 1'b0;
  endtask

  task automatic expect_restore(input int unsigned beats);
    int unsigned waited;
    int unsigned seen;
    waited = 0;
    seen   = 0;
    @(negedge clk_i);
    while (!restore.valid && waited < RestoreWaitMax) begin
      @(negedge clk_i);
      waited++;
    end
    if (!restore.valid) begin
      $display("No restore beat appeared within %0d cycles in %0s", RestoreWaitMax, test_name);
      test_ok = 1'b0;
    end else begin
      // Every beat carries the checkpoint word with the cores held
      while (restore.valid) begin
        if (restore.data !== last_word) begin
          $display("Error: %0s expected %h actual %h", test_name, last_word, restore.data);
          test_ok = 1'b0;
        end
        if (setback !== 1'b1) begin
          $display("Error: %0s setback expected 1 actual %b", test_name, setback);
          test_ok = 1'b0;
        end
        seen++;
        @(negedge clk_i);
      end
      if (seen != beats) begin
        $display("Error: %0s beats expected %0d actual %0d", test_name, beats, seen);
        test_ok = 1'b0;
      end
      if (setback !== 1'b0) begin
        $display("Error: %0s setback expected 0 actual %b", test_name, setback);
        test_ok = 1'b0;
      end
    end
  endtask

  task automatic expect_no_restore(input int unsigned n);
    repeat (n) begin
      @(negedge clk_i);
      if (restore.valid || setback) begin
        $display("Unexpected restore beat or setback during %0s", test_name);
        test_ok = 1'b0;
      end
    end
  endtask

  task automatic run_vector(input int unsigned idx);
    logic [31:0] a, d, c, e;
    a = vec_addr[idx];
    d = vec_data[idx];
    c = vec_cnt[idx];
    e = vec_exp[idx];
    test_ok   = 1'b1;
    test_name = $sformatf("%0s (vector %0d)", vec_op[idx], idx + 1);
    case (vec_op[idx])
      "WR":     write_reg(a, d);
      "RD":     read_check(a, e);
      "EQ":     step_cores(c, 1'b0);
      "NE":     step_cores(c, 1'b1);
      "FETCH": begin
        @(posedge clk_i);
        fetch_en <= d[0];
      end
      "SYNCH": begin
        @(posedge clk_i);
        cores_synch <= d[0];
      end
      "WAIT":   repeat (c) @(posedge clk_i);
      "REST":   expect_restore(e);
      "NOREST": expect_no_restore(c);
      "IND": begin
        @(negedge clk_i);
        if (grp_in_independent !== e[0]) begin
          $display("Error: %0s expected %b actual %b", test_name, e[0], grp_in_independent);
          test_ok = 1'b0;
        end
      end
      "SETB": begin
        @(negedge clk_i);
        if (setback !== e[0]) begin
          $display("Error: %0s expected %b actual %b", test_name, e[0], setback);
          test_ok = 1'b0;
        end
      end
      default: begin
        $display("Unknown operation %0s in the vector file", vec_op[idx]);
        test_ok = 1'b0;
      end
    endcase
    if (test_ok) begin
      pass_cnt++;
      $display("PASS %0s", test_name);
    end else begin
      fail_cnt++;
      $display("FAIL %0s", test_name);
    end
  endtask

  // Watchdog scaled to the number of vectors
  initial begin
    wait (vec_count > 0);
    repeat (vec_count * WatchCyclesPerVec) @(posedge clk_i);
    $display("Watchdog: the run timed out after %0d cycles", vec_count * WatchCyclesPerVec);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    reg_req     = '0;
    core_a      = '0;
    core_b      = '0;
    fetch_en    = 1'b0;
    cores_synch = 1'b0;
    last_word   = '0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    // Seed the generator once
    void'($urandom(84));
    load_vectors();
    vec_count   = vec_op.size();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    if (file_ok) begin
      for (int unsigned i = 0; i < vec_count; i++) begin
        run_vector(i);
      end
    end
    $display("Summary: %0d tests, %0d passed, %0d failed", pass_cnt + fail_cnt, pass_cnt,
             fail_cnt);
    if (file_ok && fail_cnt == 0 && vec_count > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
